// ==== verilog.f ====
+incdir+include
hw/io_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/io_uart.sv
hw/io_display_regs.sv
hw/io_bus_ctrl.sv
hw/io_subsys_top.sv
sim/tb_clock.sv
sim/io_checker.sv
sim/io_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
TOP       := io_tb
FILELIST  := verilog.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
PASS_MSG  := all tests passed

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== sim/io_tb.sv ====
// Testbench top with uart_tx looped back to uart_rx and a BAUD_DIVIDE of 8 for short frames
`include "io_cfg.svh"

module io_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import io_pkg::*;

	localparam int BAUD = 8;
	localparam int CLK_PERIOD = 4;
	localparam int DISPLAY_PASSES = 4;
	localparam int UART_BYTES = 5;   // Three loopback bytes and two overrun bytes
	localparam int WATCHDOG_CYCLES =
		2 * (16 + (DISPLAY_PASSES + 1) * 64 + UART_BYTES * 40 * BAUD);
	localparam int POLL_LIMIT = 20 * BAUD;
	localparam io_data_t BUSY = 32'd1 << `UART_STAT_TX_BUSY;
	localparam io_data_t VALID = 32'd1 << `UART_STAT_RX_VALID;
	localparam io_data_t OVERRUN = 32'd1 << `UART_STAT_RX_OVERRUN;
	localparam io_data_t UNMAPPED [4] = '{32'd32, 32'h100, 32'd2, 32'hffff_fffc};

	logic                       clk;
	logic                       arst_n;
	logic                       write_en;
	logic                       read_en;
	io_addr_t                   addr;
	io_data_t                   write_data;
	io_data_t                   read_data;
	logic [`IO_RED_WIDTH-1:0]   red_led;
	logic [`IO_GREEN_WIDTH-1:0] green_led;
	logic [`IO_HEX_WIDTH-1:0]   hex0;
	logic [`IO_HEX_WIDTH-1:0]   hex1;
	logic [`IO_HEX_WIDTH-1:0]   hex2;
	logic [`IO_HEX_WIDTH-1:0]   hex3;
	logic                       serial;      // Loopback wire
	logic [127:0]               test_name;
	io_data_t                   seed;
	int                         tb_errors;   // Poll failures
	int                         error_count;
	int                         check_count;

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(16)) clk0 (.clk(clk), .arst_n(arst_n));

	io_subsys_top #(.BAUD_DIVIDE(BAUD)) dut0 (
		.clk(clk), .arst_n(arst_n), .write_en(write_en), .read_en(read_en), .addr(addr),
		.write_data(write_data), .uart_rx(serial), .read_data(read_data), .red_led(red_led),
		.green_led(green_led), .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
		.uart_tx(serial));

	io_checker #(.BAUD_DIVIDE(BAUD)) chk0 (.*, .uart_tx(serial));

	function automatic io_data_t lcg_next(input io_data_t s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic bus_write(input io_addr_t a, input io_data_t d);
		@(posedge clk);
		write_en <= 1'b1;
		addr <= a;
		write_data <= d;
		@(posedge clk);
		write_en <= 1'b0;   // One-cycle strobe
	endtask

	task automatic bus_read(input io_addr_t a, output io_data_t d);
		@(posedge clk);
		read_en <= 1'b1;
		addr <= a;
		@(posedge clk);
		read_en <= 1'b0;
		@(posedge clk);
		d = read_data;   // Registered one cycle after the strobe
	endtask

	task automatic wait_status(input io_data_t mask, input io_data_t want, input string what);
		io_data_t v;
		int       n;
		n = 0;
		bus_read(`IO_ADDR_UART_STATUS, v);
		while ((v & mask) != want && n < POLL_LIMIT)
		begin
			bus_read(`IO_ADDR_UART_STATUS, v);
			n++;
		end
		if ((v & mask) != want)
		begin
			$display("%0s: %0s after %0d status reads", test_name, what, n);
			tb_errors++;
		end
	endtask

	task automatic send_byte();
		wait_status(BUSY, '0, "tx_busy stayed high");
		seed = lcg_next(seed);
		bus_write(`IO_ADDR_UART_DATA, seed);   // Only bits 7:0 go out
	endtask

	initial
	begin
		io_data_t v;
		write_en = 1'b0;
		read_en = 1'b0;
		addr = '0;
		write_data = '0;
		test_name = "reset";
		seed = 32'h055c_07b1;
		tb_errors = 0;
		@(posedge arst_n);
		bus_read(`IO_ADDR_UART_STATUS, v);   // Zero out of reset
		test_name <= "display";
		repeat (DISPLAY_PASSES)
		begin
			for (int i = 0; i < 6; i++)
			begin
				seed = lcg_next(seed);
				bus_write(`IO_ADDR_RED_LED + 32'(4 * i), seed);   // Upper bits must drop
			end
			for (int i = 0; i < 6; i++)
				bus_read(`IO_ADDR_RED_LED + 32'(4 * i), v);
		end
		test_name <= "unmapped";
		for (int i = 0; i < 4; i++)
		begin
			seed = lcg_next(seed);
			bus_write(UNMAPPED[i], seed);
			bus_read(UNMAPPED[i], v);
		end
		test_name <= "uart_loopback";
		repeat (3)
		begin
			send_byte();
			wait_status(BUSY | VALID, VALID, "rx_valid never set");
			bus_read(`IO_ADDR_UART_DATA, v);
			bus_read(`IO_ADDR_UART_STATUS, v);   // Flags cleared by the data read
		end
		test_name <= "overrun";
		send_byte();
		send_byte();   // No read in between
		wait_status(BUSY | VALID | OVERRUN, VALID | OVERRUN, "second byte never arrived");
		bus_read(`IO_ADDR_UART_STATUS, v);
		bus_read(`IO_ADDR_UART_DATA, v);
		bus_read(`IO_ADDR_UART_STATUS, v);
		@(posedge clk);
		$display("checks %0d errors %0d", check_count, error_count + tb_errors);
		if (error_count + tb_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end
endmodule

// ==== sim/io_checker.sv ====
// Bus monitor with a register model; rx flags go unchecked while a looped-back frame may be landing
`include "io_cfg.svh"

module io_checker #(
	parameter int BAUD_DIVIDE = 8
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [127:0]               test_name,
	input  logic                       write_en,
	input  logic                       read_en,
	input  io_pkg::io_addr_t           addr,
	input  io_pkg::io_data_t           write_data,
	input  io_pkg::io_data_t           read_data,
	input  logic [`IO_RED_WIDTH-1:0]   red_led,
	input  logic [`IO_GREEN_WIDTH-1:0] green_led,
	input  logic [`IO_HEX_WIDTH-1:0]   hex0,
	input  logic [`IO_HEX_WIDTH-1:0]   hex1,
	input  logic [`IO_HEX_WIDTH-1:0]   hex2,
	input  logic [`IO_HEX_WIDTH-1:0]   hex3,
	input  logic                       uart_tx,
	output int                         error_count,
	output int                         check_count
);
	timeunit 1ns;
	timeprecision 100ps;
	import io_pkg::*;

	localparam int FRAME = 10 * BAUD_DIVIDE;   // Start, eight data, stop

	io_data_t   model [8];      // Display registers by addr[4:2]
	int         cyc;            // Clocks since reset release
	int         tx_cyc;         // Edge of last accepted send
	int         sent_cyc [$];   // Frames in flight, oldest first
	logic [7:0] sent_byte [$];
	logic       m_valid;
	logic       m_overrun;
	logic       m_have;         // Any byte landed yet
	logic [7:0] m_data;
	logic       rd_pend;        // Read result due this edge
	io_data_t   rd_exp;
	io_data_t   rd_mask;

	function automatic logic is_display(input io_addr_t a);
		return a <= `IO_ADDR_HEX3 && a[1:0] == 2'b00;   // Six consecutive words from zero
	endfunction

	function automatic io_data_t width_mask(input logic [2:0] idx);
		case (idx)
			3'd0: return (32'd1 << `IO_RED_WIDTH) - 32'd1;
			3'd1: return (32'd1 << `IO_GREEN_WIDTH) - 32'd1;
			default: return (32'd1 << `IO_HEX_WIDTH) - 32'd1;
		endcase
	endfunction

	function automatic logic tx_active(input int c);
		return tx_cyc >= 0 && c > tx_cyc && c <= tx_cyc + FRAME;   // Busy seen on these edges
	endfunction

	function automatic logic rx_unsure();
		return sent_cyc.size() > 0 && cyc >= sent_cyc[0] + 9 * BAUD_DIVIDE;   // Stop bit region
	endfunction

	// Expected read value; known marks the bits that are certain on this edge
	function automatic io_data_t io_expect(input io_addr_t a, output io_data_t known);
		io_data_t v;
		v = '0;   // Unmapped reads as zero
		known = '1;
		if (is_display(a))
			v = model[a[4:2]];
		else if (a == `IO_ADDR_UART_STATUS)
		begin
			v[`UART_STAT_TX_BUSY] = tx_active(cyc);
			v[`UART_STAT_RX_VALID] = m_valid;
			v[`UART_STAT_RX_OVERRUN] = m_overrun;
			if (rx_unsure())
				known = ~((32'd1 << `UART_STAT_RX_VALID) | (32'd1 << `UART_STAT_RX_OVERRUN));
		end
		else if (a == `IO_ADDR_UART_DATA)
		begin
			v = {24'd0, m_data};
			if (rx_unsure() || !m_have)
				known = 32'hffff_ff00;   // Upper bits still zero
		end
		return v;
	endfunction

	task automatic compare(input string what, input io_data_t expected, input io_data_t actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("ERR %0s %0s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	always @(posedge clk)
	begin
		if (!arst_n)
		begin
			foreach (model[i])
				model[i] = '0;
			cyc = 0;
			tx_cyc = -1;   // Nothing sent
			sent_cyc.delete();
			sent_byte.delete();
			m_valid = 1'b0;
			m_overrun = 1'b0;
			m_have = 1'b0;
			rd_pend = 1'b0;
			error_count = 0;
			check_count = 0;
		end
		else
		begin
			cyc = cyc + 1;
			if (sent_cyc.size() > 0 && cyc >= sent_cyc[0] + FRAME + 4)
			begin
				m_overrun = m_overrun | m_valid;   // Unread byte overwritten
				m_valid = 1'b1;
				m_have = 1'b1;
				m_data = sent_byte[0];   // Loopback returns what was sent
				sent_byte.delete(0);
				sent_cyc.delete(0);
			end
			if (rd_pend)
				compare("read_data", rd_exp & rd_mask, read_data & rd_mask);
			rd_pend = read_en;
			compare("red_led", model[0], io_data_t'(red_led));
			compare("green_led", model[1], io_data_t'(green_led));
			compare("hex0", model[2], io_data_t'(hex0));
			compare("hex1", model[3], io_data_t'(hex1));
			compare("hex2", model[4], io_data_t'(hex2));
			compare("hex3", model[5], io_data_t'(hex3));
			if (!tx_active(cyc))
				compare("uart_tx idle", 32'd1, io_data_t'(uart_tx));   // Line high between frames
			if (read_en)
			begin
				rd_exp = io_expect(addr, rd_mask);
				if (addr == `IO_ADDR_UART_DATA)
				begin
					m_valid = 1'b0;   // Data read clears both flags
					m_overrun = 1'b0;
				end
			end
			if (write_en && is_display(addr))
				model[addr[4:2]] = write_data & width_mask(addr[4:2]);
			else if (write_en && addr == `IO_ADDR_UART_DATA && !tx_active(cyc))
			begin
				tx_cyc = cyc;   // Writes while busy are dropped
				sent_cyc.push_back(cyc);
				sent_byte.push_back(write_data[7:0]);
			end
		end
	end
endmodule

// ==== sim/tb_clock.sv ====
// Free-running clock and power-on reset; reset is released by a rising edge after RESET_CYCLES
module tb_clock #(
	parameter int PERIOD_NS    = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial
	begin
		arst_n = 1'b0;   // Held from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end
endmodule

// ==== hw/io_subsys_top.sv ====
// I/O subsystem top; uart_rx is asynchronous and synchronized inside, all else runs on clk
`include "io_cfg.svh"

module io_subsys_top #(
	parameter int BAUD_DIVIDE = `IO_BAUD_DIVIDE_DEFAULT
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       write_en,
	input  logic                       read_en,
	input  io_pkg::io_addr_t           addr,
	input  io_pkg::io_data_t           write_data,
	input  logic                       uart_rx,
	output io_pkg::io_data_t           read_data,
	output logic [`IO_RED_WIDTH-1:0]   red_led,
	output logic [`IO_GREEN_WIDTH-1:0] green_led,
	output logic [`IO_HEX_WIDTH-1:0]   hex0,
	output logic [`IO_HEX_WIDTH-1:0]   hex1,
	output logic [`IO_HEX_WIDTH-1:0]   hex2,
	output logic [`IO_HEX_WIDTH-1:0]   hex3,
	output logic                       uart_tx
);
	import io_pkg::*;

	logic       wr;              // Mapped write
	logic       rd;              // Mapped read
	io_target_e target;
	io_data_t   display_rdata;
	io_data_t   uart_rdata;

	io_bus_ctrl bus0 (
		.clk(clk), .arst_n(arst_n), .write_en(write_en), .read_en(read_en), .addr(addr),
		.display_rdata(display_rdata), .uart_rdata(uart_rdata),
		.wr(wr), .rd(rd), .target(target), .read_data(read_data));

	io_display_regs disp0 (
		.clk(clk), .arst_n(arst_n), .wr(wr), .target(target), .write_data(write_data),
		.display_rdata(display_rdata), .red_led(red_led), .green_led(green_led),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3));

	io_uart #(.BAUD_DIVIDE(BAUD_DIVIDE)) uart0 (
		.clk(clk), .arst_n(arst_n), .wr(wr), .rd(rd), .target(target),
		.write_data(write_data), .uart_rx(uart_rx),
		.uart_rdata(uart_rdata), .uart_tx(uart_tx));
endmodule

// ==== hw/io_bus_ctrl.sv ====
// Address decode and read capture; strobes are single-cycle and never both high, read data lags one cycle
`include "io_cfg.svh"

module io_bus_ctrl (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               write_en,
	input  logic               read_en,
	input  io_pkg::io_addr_t   addr,
	input  io_pkg::io_data_t   display_rdata,
	input  io_pkg::io_data_t   uart_rdata,
	output logic               wr,
	output logic               rd,
	output io_pkg::io_target_e target,
	output io_pkg::io_data_t   read_data
);
	import io_pkg::*;

	io_data_t rdata_sel;   // Value of the addressed register

	always_comb
	begin
		case (addr)   // Full compare, no aliasing
			`IO_ADDR_RED_LED: target = IO_RED_LED;
			`IO_ADDR_GREEN_LED: target = IO_GREEN_LED;
			`IO_ADDR_HEX0: target = IO_HEX0;
			`IO_ADDR_HEX1: target = IO_HEX1;
			`IO_ADDR_HEX2: target = IO_HEX2;
			`IO_ADDR_HEX3: target = IO_HEX3;
			`IO_ADDR_UART_STATUS: target = IO_UART_STATUS;
			`IO_ADDR_UART_DATA: target = IO_UART_DATA;
			default: target = IO_NONE;
		endcase
	end

	assign wr = write_en && target != IO_NONE;   // Unmapped writes vanish
	assign rd = read_en && target != IO_NONE;

	always_comb
	begin
		case (target)
			IO_RED_LED, IO_GREEN_LED, IO_HEX0, IO_HEX1, IO_HEX2, IO_HEX3:
				rdata_sel = display_rdata;
			IO_UART_STATUS, IO_UART_DATA: rdata_sel = uart_rdata;
			default: rdata_sel = '0;   // Unmapped reads return zero
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			read_data <= '0;
		else if (read_en)
			read_data <= rdata_sel;   // Held until next read
	end
endmodule

// ==== hw/io_display_regs.sv ====
// LED and seven-segment registers; writes keep only the low bits of each field, reads zero-extend
`include "io_cfg.svh"

module io_display_regs (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       wr,
	input  io_pkg::io_target_e         target,
	input  io_pkg::io_data_t           write_data,
	output io_pkg::io_data_t           display_rdata,
	output logic [`IO_RED_WIDTH-1:0]   red_led,
	output logic [`IO_GREEN_WIDTH-1:0] green_led,
	output logic [`IO_HEX_WIDTH-1:0]   hex0,
	output logic [`IO_HEX_WIDTH-1:0]   hex1,
	output logic [`IO_HEX_WIDTH-1:0]   hex2,
	output logic [`IO_HEX_WIDTH-1:0]   hex3
);
	import io_pkg::*;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			red_led <= '0;   // All lamps off
			green_led <= '0;
			hex0 <= '0;
			hex1 <= '0;
			hex2 <= '0;
			hex3 <= '0;
		end
		else if (wr)
		begin
			case (target)
				IO_RED_LED: red_led <= write_data[`IO_RED_WIDTH-1:0];
				IO_GREEN_LED: green_led <= write_data[`IO_GREEN_WIDTH-1:0];
				IO_HEX0: hex0 <= write_data[`IO_HEX_WIDTH-1:0];
				IO_HEX1: hex1 <= write_data[`IO_HEX_WIDTH-1:0];
				IO_HEX2: hex2 <= write_data[`IO_HEX_WIDTH-1:0];
				IO_HEX3: hex3 <= write_data[`IO_HEX_WIDTH-1:0];
				default: ;   // UART or unmapped
			endcase
		end
	end

	always_comb
	begin
		case (target)
			IO_RED_LED: display_rdata = io_data_t'(red_led);
			IO_GREEN_LED: display_rdata = io_data_t'(green_led);
			IO_HEX0: display_rdata = io_data_t'(hex0);
			IO_HEX1: display_rdata = io_data_t'(hex1);
			IO_HEX2: display_rdata = io_data_t'(hex2);
			IO_HEX3: display_rdata = io_data_t'(hex3);
			default: display_rdata = '0;
		endcase
	end
endmodule

// ==== hw/io_uart.sv ====
// UART register pair; no back-pressure, software polls busy before writing the data register
`include "io_cfg.svh"

module io_uart #(
	parameter int BAUD_DIVIDE = `IO_BAUD_DIVIDE_DEFAULT
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               wr,
	input  logic               rd,
	input  io_pkg::io_target_e target,
	input  io_pkg::io_data_t   write_data,
	input  logic               uart_rx,
	output io_pkg::io_data_t   uart_rdata,
	output logic               uart_tx
);
	import io_pkg::*;

	logic       tx_start;
	logic       tx_busy;
	logic       rx_strobe;
	logic [7:0] rx_byte;
	logic [7:0] rx_data;      // Last received byte
	logic       rx_valid;
	logic       rx_overrun;   // Byte lost before read
	io_data_t   status;

	assign tx_start = wr && target == IO_UART_DATA && !tx_busy;   // Dropped when busy

	uart_tx #(.BAUD_DIVIDE(BAUD_DIVIDE)) tx0 (
		.clk(clk), .arst_n(arst_n), .tx_start(tx_start), .tx_byte(write_data[7:0]),
		.tx_busy(tx_busy), .tx(uart_tx));

	uart_rx #(.BAUD_DIVIDE(BAUD_DIVIDE)) rx0 (
		.clk(clk), .arst_n(arst_n), .rx(uart_rx),
		.rx_strobe(rx_strobe), .rx_byte(rx_byte));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_valid <= 1'b0;
			rx_overrun <= 1'b0;
		end
		else if (rx_strobe)
		begin
			rx_valid <= 1'b1;
			rx_overrun <= rx_valid && !(rd && target == IO_UART_DATA);   // Unread byte lost
		end
		else if (rd && target == IO_UART_DATA)
		begin
			rx_valid <= 1'b0;
			rx_overrun <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_strobe)
			rx_data <= rx_byte;   // Newest byte wins
	end

	always_comb
	begin
		status = '0;
		status[`UART_STAT_TX_BUSY] = tx_busy;
		status[`UART_STAT_RX_VALID] = rx_valid;
		status[`UART_STAT_RX_OVERRUN] = rx_overrun;
		case (target)
			IO_UART_STATUS: uart_rdata = status;
			IO_UART_DATA: uart_rdata = {24'd0, rx_data};
			default: uart_rdata = '0;   // Not ours
		endcase
	end
endmodule

// ==== hw/uart_rx.sv ====
// 8N1 receiver; BAUD_DIVIDE of 4 or more, framing errors drop the byte silently
module uart_rx #(
	parameter int BAUD_DIVIDE = 217
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       rx,
	output logic       rx_strobe,
	output logic [7:0] rx_byte
);
	localparam int CNT_W = $clog2(BAUD_DIVIDE);
	localparam int HALF  = BAUD_DIVIDE / 2 - 1;   // Mid-bit offset from edge detect

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e        state;
	logic             rx_meta;    // First sync flop
	logic             rx_sync;    // Safe to use
	logic             rx_prev;    // For falling edge
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_cnt;
	logic             bit_done;

	assign bit_done = cnt == CNT_W'(BAUD_DIVIDE - 1);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			state <= RX_IDLE;
			cnt <= '0;
			bit_cnt <= '0;
			rx_strobe <= 1'b0;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			rx_strobe <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				RX_IDLE:
				begin
					cnt <= '0;
					if (rx_prev && !rx_sync)
						state <= RX_START;   // Falling edge, maybe a start bit
				end
				RX_START:
					if (cnt == CNT_W'(HALF))
					begin
						cnt <= '0;
						bit_cnt <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;   // Glitch if high again
					end
				RX_DATA:
					if (bit_done)
					begin
						cnt <= '0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				default:   // RX_STOP, sampled mid-bit
					if (bit_done)
					begin
						rx_strobe <= rx_sync;   // Only a high stop bit counts
						state <= RX_IDLE;
					end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == RX_DATA && bit_done)
			rx_byte <= {rx_sync, rx_byte[7:1]};   // LSB arrives first
	end
endmodule

// ==== hw/uart_tx.sv ====
// 8N1 serializer; BAUD_DIVIDE must be at least 2 and tx_start is ignored while busy
module uart_tx #(
	parameter int BAUD_DIVIDE = 217
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_busy,
	output logic       tx
);
	localparam int CNT_W = $clog2(BAUD_DIVIDE);

	logic [CNT_W-1:0] baud_cnt;   // Clocks into current bit
	logic [3:0]       bit_cnt;    // 0 is start bit, 9 is stop bit
	logic [8:0]       shift_q;    // Remaining data bits plus stop
	logic             bit_done;

	assign bit_done = baud_cnt == CNT_W'(BAUD_DIVIDE - 1);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tx_busy <= 1'b0;
			tx <= 1'b1;   // Line idles high
			baud_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (!tx_busy)
		begin
			if (tx_start)
			begin
				tx_busy <= 1'b1;
				tx <= 1'b0;   // Start bit
				baud_cnt <= '0;
				bit_cnt <= '0;
			end
		end
		else if (bit_done)
		begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0;   // Stop bit done, tx already high
			else
			begin
				tx <= shift_q[0];   // LSB first, stop bit last
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
		else
			baud_cnt <= baud_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!tx_busy && tx_start)
			shift_q <= {1'b1, tx_byte};   // Stop bit above data
		else if (tx_busy && bit_done)
			shift_q <= {1'b1, shift_q[8:1]};
	end
endmodule

// ==== hw/io_pkg.sv ====
// Bus types shared by the I/O subsystem; target encoding is internal and may be renumbered freely
package io_pkg;

	typedef logic [31:0] io_addr_t;   // Byte address from the core
	typedef logic [31:0] io_data_t;   // Read and write data word

	// One value per mapped register, IO_NONE for anything else
	typedef enum logic [3:0]
	{
		IO_NONE        = 4'd0,
		IO_RED_LED     = 4'd1,
		IO_GREEN_LED   = 4'd2,
		IO_HEX0        = 4'd3,
		IO_HEX1        = 4'd4,
		IO_HEX2        = 4'd5,
		IO_HEX3        = 4'd6,
		IO_UART_STATUS = 4'd7,
		IO_UART_DATA   = 4'd8
	} io_target_e;

endpackage

// ==== include/io_cfg.svh ====
// Register map and widths of the I/O subsystem; addresses are byte offsets decoded at full 32 bits
`ifndef IO_CFG_SVH
`define IO_CFG_SVH

`define IO_ADDR_RED_LED       32'd0    // Red LED bank
`define IO_ADDR_GREEN_LED     32'd4    // Green LED bank
`define IO_ADDR_HEX0          32'd8    // Seven-segment digits, one word each
`define IO_ADDR_HEX1          32'd12
`define IO_ADDR_HEX2          32'd16
`define IO_ADDR_HEX3          32'd20
`define IO_ADDR_UART_STATUS   32'd24   // Read only
`define IO_ADDR_UART_DATA     32'd28   // Write sends, read takes rx byte

`define IO_RED_WIDTH          18
`define IO_GREEN_WIDTH        9
`define IO_HEX_WIDTH          7        // Segments a..g, no decimal point

`define IO_BAUD_DIVIDE_DEFAULT 217     // Clocks per bit, 115200 baud at 25 MHz

`define UART_STAT_TX_BUSY     0
`define UART_STAT_RX_VALID    1
`define UART_STAT_RX_OVERRUN  2
`endif
